//--- compile.f
logic/time_pkg.sv
logic/link_pkg.sv
logic/set_time_parser.sv
logic/rtc_sequencer.sv
logic/display_writer.sv
logic/hour_chime.sv
logic/wifi_clock_top.sv
testbench/clock_tb.sv

//--- logic/display_writer.sv
`timescale 1ns/1ps

module display_writer #(
    parameter int BLINK_CYCLES = 2**24
) (
    input  logic                   clk,
    input  logic                   reset,
    input  time_pkg::clock_time_t  reading,
    input  logic                   read_strobe,
    output time_pkg::display_out_t display,
    input  logic                   display_ready
);
    localparam int WORDS = 2 * time_pkg::DIGITS;
    localparam int IDX_W = $clog2(WORDS);
    localparam int BLINK_W = $clog2(BLINK_CYCLES + 1);
    localparam logic [IDX_W-1:0] LAST_WORD = IDX_W'(WORDS - 1);
    localparam logic [IDX_W-1:0] BLINK_WORD = IDX_W'(3);

    time_pkg::clock_time_t   next_time;
    time_pkg::clock_time_t   cur_time;
    logic                    next_pending;
    logic                    busy;
    logic                    gap;
    logic                    send;
    logic [IDX_W-1:0]        idx;
    logic [BLINK_W-1:0]      blink_cnt;
    logic                    blink;
    logic [3:0]              nibble;
    time_pkg::display_word_u word;

    // blank for anything that is not a decimal digit.
    function automatic logic [6:0] bcd_to_seg(input logic [3:0] d);
        case (d)
            4'd0: return 7'b0111111;
            4'd1: return 7'b0000110;
            4'd2: return 7'b1011011;
            4'd3: return 7'b1001111;
            4'd4: return 7'b1100110;
            4'd5: return 7'b1101101;
            4'd6: return 7'b1111101;
            4'd7: return 7'b0000111;
            4'd8: return 7'b1111111;
            4'd9: return 7'b1101111;
            default: return 7'b0000000;
        endcase
    endfunction

    // ==================================================
    // word building
    // ==================================================

    always_comb begin
        case (idx[IDX_W-1:1])
            2'd0: nibble = cur_time.hr[7:4];
            2'd1: nibble = cur_time.hr[3:0];
            2'd2: nibble = cur_time.min[7:4];
            default: nibble = cur_time.min[3:0];
        endcase
    end

    // even words address a digit, odd words carry its glyph.
    always_comb begin
        word = '0;
        if (!idx[0]) begin
            word.pos_cmd.tag = time_pkg::DIGIT_TAG;
            word.pos_cmd.pos = idx[IDX_W-1:1];
        end else begin
            word.glyph.seg = bcd_to_seg(nibble);
            word.glyph.dp  = blink && (idx == BLINK_WORD);
        end
    end

    assign send = busy && !gap && display_ready;
    assign display.valid = send;
    assign display.word = word;

    // ==================================================
    // frame control
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            next_pending <= 1'b0;
            busy         <= 1'b0;
            gap          <= 1'b0;
            idx          <= '0;
        end else begin
            gap <= send;
            if (read_strobe) begin
                next_pending <= 1'b1;
            end

            if (!busy && next_pending) begin
                busy         <= 1'b1;
                idx          <= '0;
                next_pending <= read_strobe;
            end else if (send) begin
                if (idx == LAST_WORD) begin
                    busy <= 1'b0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // a reading during a frame waits for the next one.
    always_ff @(posedge clk) begin
        if (read_strobe) begin
            next_time <= reading;
        end
        if (!busy && next_pending) begin
            cur_time <= next_time;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            blink_cnt <= '0;
            blink     <= 1'b0;
        end else if (blink_cnt == BLINK_W'(BLINK_CYCLES - 1)) begin
            blink_cnt <= '0;
            blink     <= ~blink;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    word_on_ready: assert property (
        @(posedge clk) disable iff (reset)
        display.valid |-> display_ready ##1 !display.valid
    );

endmodule

//--- logic/hour_chime.sv
`timescale 1ns/1ps

module hour_chime #(
    parameter int CHIME_CYCLES = 2**20
) (
    input  logic                  clk,
    input  logic                  reset,
    input  time_pkg::clock_time_t reading,
    input  logic                  read_strobe,
    output logic                  buzz
);
    localparam int CNT_W = $clog2(CHIME_CYCLES + 1);

    time_pkg::bcd_t   last_hr;
    logic [CNT_W-1:0] buzz_cnt;
    logic             hour_changed;

    assign hour_changed = read_strobe && (reading.hr != last_hr);

    // a fresh change restarts the full chime.
    always_ff @(posedge clk) begin
        if (reset) begin
            last_hr  <= '0;
            buzz_cnt <= '0;
            buzz     <= 1'b0;
        end else if (hour_changed) begin
            last_hr  <= reading.hr;
            buzz_cnt <= '0;
            buzz     <= 1'b1;
        end else if (buzz) begin
            if (buzz_cnt == CNT_W'(CHIME_CYCLES - 1)) begin
                buzz <= 1'b0;
            end else begin
                buzz_cnt <= buzz_cnt + 1'b1;
            end
        end
    end

endmodule

//--- logic/link_pkg.sv
package link_pkg;

    // ==================================================
    // byte streams
    // ==================================================

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_strobe_t;

    // ==================================================
    // i2c byte master items
    // ==================================================

    typedef enum logic {
        START = 1'b0,
        DATA  = 1'b1
    } i2c_kind_e;

    // count is the number of bytes to read after a read start.
    typedef struct packed {
        logic       valid;
        i2c_kind_e  kind;
        logic       rw;
        logic [6:0] addr;
        logic [1:0] count;
        logic [7:0] data;
    } i2c_item_t;

    // ==================================================
    // packet and rtc constants
    // ==================================================

    localparam logic [7:0] HEADER_SET = 8'hAA;
    localparam logic [7:0] ANSWER_ACK = 8'hAA;
    localparam logic [7:0] ANSWER_NACK = 8'hBB;
    localparam int PACKET_BYTES = 4;

    // pointer to the seconds register, start of the time block.
    localparam logic [7:0] RTC_TIME_REG = 8'h00;

endpackage

//--- logic/rtc_sequencer.sv
`timescale 1ns/1ps

module rtc_sequencer #(
    parameter logic [6:0] RTC_ADDR      = 7'h68,
    parameter int         READ_INTERVAL = 2**20
) (
    input  logic                   clk,
    input  logic                   reset,
    input  time_pkg::clock_time_t  set_time,
    input  logic                   set_strobe,
    output link_pkg::i2c_item_t    i2c_cmd,
    input  logic                   i2c_ready,
    input  link_pkg::byte_strobe_t i2c_rd,
    output time_pkg::clock_time_t  reading,
    output logic                   read_strobe
);
    localparam int INT_W = $clog2(READ_INTERVAL + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SEND,
        S_GAP,
        S_READ
    } state_e;

    state_e                state;
    logic                  op_read;
    logic [2:0]            step;
    logic                  last_step;
    logic                  write_pending;
    time_pkg::clock_time_t pend_time;
    time_pkg::clock_time_t wr_time;
    logic [INT_W-1:0]      interval_cnt;
    logic [1:0]            rd_cnt;
    logic                  rd_last;
    link_pkg::i2c_item_t   item;

    // write list has five items, read list three.
    assign last_step = op_read ? (step == 3'd2) : (step == 3'd4);
    assign rd_last = (state == S_READ) && i2c_rd.valid && (rd_cnt == 2'd2);

    // ==================================================
    // transaction FSM
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= S_IDLE;
            op_read       <= 1'b0;
            step          <= '0;
            write_pending <= 1'b0;
            interval_cnt  <= '0;
            rd_cnt        <= '0;
        end else begin
            if (set_strobe) begin
                write_pending <= 1'b1;
            end

            case (state)
                S_IDLE: begin
                    step   <= '0;
                    rd_cnt <= '0;
                    if (write_pending) begin
                        op_read       <= 1'b0;
                        write_pending <= set_strobe;
                        state         <= S_SEND;
                    end else if (interval_cnt == INT_W'(READ_INTERVAL - 1)) begin
                        op_read <= 1'b1;
                        state   <= S_SEND;
                    end else begin
                        interval_cnt <= interval_cnt + 1'b1;
                    end
                end
                S_SEND: begin
                    if (i2c_ready) begin
                        state <= S_GAP;
                    end
                end
                S_GAP: begin
                    if (!last_step) begin
                        step  <= step + 1'b1;
                        state <= S_SEND;
                    end else if (op_read) begin
                        state <= S_READ;
                    end else begin
                        interval_cnt <= '0;
                        state        <= S_IDLE;
                    end
                end
                S_READ: begin
                    if (i2c_rd.valid) begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                    if (rd_last) begin
                        interval_cnt <= '0;
                        state        <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ==================================================
    // item lists
    // ==================================================

    always_comb begin
        item      = '0;
        item.kind = link_pkg::DATA;
        case (step)
            3'd0: begin
                item.kind = link_pkg::START;
                item.addr = RTC_ADDR;
            end
            3'd1: item.data = link_pkg::RTC_TIME_REG;
            3'd2: begin
                if (op_read) begin
                    item.kind  = link_pkg::START;
                    item.rw    = 1'b1;
                    item.addr  = RTC_ADDR;
                    item.count = 2'd3;
                end else begin
                    item.data = wr_time.sec;
                end
            end
            3'd3: item.data = wr_time.min;
            default: item.data = wr_time.hr;
        endcase
        item.valid = (state == S_SEND) && i2c_ready;
    end

    assign i2c_cmd = item;

    // ==================================================
    // time registers
    // ==================================================

    // a newer packet may land while a write is still going out.
    always_ff @(posedge clk) begin
        if (set_strobe) begin
            pend_time <= set_time;
        end
        if (state == S_IDLE && write_pending) begin
            wr_time <= pend_time;
        end
    end

    // bytes come back as sec, min, hr.
    always_ff @(posedge clk) begin
        if (state == S_READ && i2c_rd.valid) begin
            case (rd_cnt)
                2'd0: reading.sec <= i2c_rd.data;
                2'd1: reading.min <= i2c_rd.data;
                default: reading.hr <= i2c_rd.data;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            read_strobe <= 1'b0;
        end else begin
            read_strobe <= rd_last;
        end
    end

    // every item goes out on ready and is followed by an idle cycle.
    item_on_ready: assert property (
        @(posedge clk) disable iff (reset)
        i2c_cmd.valid |-> i2c_ready ##1 !i2c_cmd.valid
    );

endmodule

//--- logic/set_time_parser.sv
`timescale 1ns/1ps

module set_time_parser (
    input  logic                   clk,
    input  logic                   reset,
    input  link_pkg::byte_strobe_t rx,
    output link_pkg::byte_strobe_t answer,
    output time_pkg::clock_time_t  set_time,
    output logic                   set_strobe
);
    localparam int CNT_W = $clog2(link_pkg::PACKET_BYTES);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(link_pkg::PACKET_BYTES - 1);

    logic [CNT_W-1:0] byte_cnt;
    logic             header_ok;
    logic             last_byte;
    time_pkg::bcd_t   hr_q;
    time_pkg::bcd_t   min_q;

    assign last_byte = rx.valid && (byte_cnt == LAST_BYTE);

    // ==================================================
    // packet counting and answer
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt   <= '0;
            header_ok  <= 1'b0;
            answer     <= '0;
            set_strobe <= 1'b0;
        end else begin
            answer.valid <= last_byte;
            set_strobe   <= last_byte && header_ok;

            if (last_byte) begin
                answer.data <= header_ok ? link_pkg::ANSWER_ACK : link_pkg::ANSWER_NACK;
            end

            if (rx.valid) begin
                if (byte_cnt == LAST_BYTE) begin
                    byte_cnt <= '0;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end

                // first byte decides the answer for the whole packet.
                if (byte_cnt == '0) begin
                    header_ok <= (rx.data == link_pkg::HEADER_SET);
                end
            end
        end
    end

    // ==================================================
    // time fields
    // ==================================================

    // hours and minutes wait here until the seconds byte closes the packet.
    always_ff @(posedge clk) begin
        if (rx.valid) begin
            case (byte_cnt)
                CNT_W'(1): hr_q <= rx.data;
                CNT_W'(2): min_q <= rx.data;
                default: ;
            endcase
        end

        if (last_byte) begin
            set_time.hr  <= hr_q;
            set_time.min <= min_q;
            set_time.sec <= rx.data;
        end
    end

    // an answer only ever follows the last byte of a packet.
    answer_after_last: assert property (
        @(posedge clk) disable iff (reset)
        (answer.valid || set_strobe) |-> $past(rx.valid) && (byte_cnt == '0)
    );

endmodule

//--- logic/time_pkg.sv
package time_pkg;

    // ==================================================
    // time values
    // ==================================================

    // two bcd digits, tens in the upper nibble.
    typedef logic [7:0] bcd_t;

    typedef struct packed {
        bcd_t hr;
        bcd_t min;
        bcd_t sec;
    } clock_time_t;

    // ==================================================
    // display words
    // ==================================================

    typedef struct packed {
        logic [5:0] tag;
        logic [1:0] pos;
    } pos_cmd_t;

    // segment bit 0 is a, bit 6 is g.
    typedef struct packed {
        logic       dp;
        logic [6:0] seg;
    } glyph_t;

    typedef union packed {
        pos_cmd_t pos_cmd;
        glyph_t   glyph;
    } display_word_u;

    typedef struct packed {
        logic          valid;
        display_word_u word;
    } display_out_t;

    // tag plus position gives addresses C0 to C3.
    localparam logic [5:0] DIGIT_TAG = 6'b110000;
    localparam int DIGITS = 4;

endpackage

//--- logic/wifi_clock_top.sv
`timescale 1ns/1ps

module wifi_clock_top #(
    parameter logic [6:0] RTC_ADDR      = 7'h68,
    parameter int         READ_INTERVAL = 2**20,
    parameter int         BLINK_CYCLES  = 2**24,
    parameter int         CHIME_CYCLES  = 2**20
) (
    input  logic                   clk,
    input  logic                   reset,
    input  link_pkg::byte_strobe_t rx,
    output link_pkg::byte_strobe_t answer,
    output link_pkg::i2c_item_t    i2c_cmd,
    input  logic                   i2c_ready,
    input  link_pkg::byte_strobe_t i2c_rd,
    output time_pkg::display_out_t display,
    input  logic                   display_ready,
    output logic                   buzz
);
    time_pkg::clock_time_t set_time;
    logic                  set_strobe;
    time_pkg::clock_time_t reading;
    logic                  read_strobe;

    set_time_parser set_time_parser_i (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .answer     (answer),
        .set_time   (set_time),
        .set_strobe (set_strobe)
    );

    rtc_sequencer #(
        .RTC_ADDR      (RTC_ADDR),
        .READ_INTERVAL (READ_INTERVAL)
    ) rtc_sequencer_i (
        .clk         (clk),
        .reset       (reset),
        .set_time    (set_time),
        .set_strobe  (set_strobe),
        .i2c_cmd     (i2c_cmd),
        .i2c_ready   (i2c_ready),
        .i2c_rd      (i2c_rd),
        .reading     (reading),
        .read_strobe (read_strobe)
    );

    display_writer #(
        .BLINK_CYCLES (BLINK_CYCLES)
    ) display_writer_i (
        .clk           (clk),
        .reset         (reset),
        .reading       (reading),
        .read_strobe   (read_strobe),
        .display       (display),
        .display_ready (display_ready)
    );

    hour_chime #(
        .CHIME_CYCLES (CHIME_CYCLES)
    ) hour_chime_i (
        .clk         (clk),
        .reset       (reset),
        .reading     (reading),
        .read_strobe (read_strobe),
        .buzz        (buzz)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the clock testbench with Verilator.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module clock_tb -f compile.f -Mdir obj_dir -o clock_sim \
    > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/clock_sim > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation ended without a result"; exit 1; }

//--- testbench/clock_tb.sv
`timescale 1ns/1ps

module clock_tb;

    localparam logic [6:0] RTC_ADDR = 7'h68;
    localparam int READ_INTERVAL = 600;
    localparam int BLINK_CYCLES = 64;
    localparam int CHIME_CYCLES = 40;
    localparam int PACKETS = 3;
    localparam int READS = 5;
    localparam int TIMEOUT_CYCLES = (PACKETS + READS) * (READ_INTERVAL + 300);
    localparam logic [31:0] SEED = 32'h21a9_d728;

    // segments a to g in bits 0 to 6.
    localparam logic [6:0] SEG_TABLE [10] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07, 7'h7F, 7'h6F
    };

    logic                   clk;
    logic                   reset;
    link_pkg::byte_strobe_t rx;
    link_pkg::byte_strobe_t answer;
    link_pkg::i2c_item_t    i2c_cmd;
    logic                   i2c_ready;
    link_pkg::byte_strobe_t i2c_rd;
    time_pkg::display_out_t display;
    logic                   display_ready;
    logic                   buzz;

    logic [7:0]            exp_answers [$];
    link_pkg::i2c_item_t   exp_items [$];
    logic [7:0]            exp_words [$];
    time_pkg::clock_time_t exp_reads [$];

    time_pkg::clock_time_t exp_time;
    time_pkg::clock_time_t rtc_time;
    time_pkg::clock_time_t read_time;
    time_pkg::bcd_t        last_hr;
    logic [7:0]            exp_word;
    logic [7:0]            got_word;
    int                    cycle = 0;
    int                    frames_done = 0;
    int                    word_idx = 0;
    int                    rd_bytes = 0;
    int                    buzz_from = 0;
    int                    buzz_until = 0;

    wifi_clock_top #(
        .RTC_ADDR      (RTC_ADDR),
        .READ_INTERVAL (READ_INTERVAL),
        .BLINK_CYCLES  (BLINK_CYCLES),
        .CHIME_CYCLES  (CHIME_CYCLES)
    ) wifi_clock_top_i (
        .clk           (clk),
        .reset         (reset),
        .rx            (rx),
        .answer        (answer),
        .i2c_cmd       (i2c_cmd),
        .i2c_ready     (i2c_ready),
        .i2c_rd        (i2c_rd),
        .display       (display),
        .display_ready (display_ready),
        .buzz          (buzz)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // ==================================================
    // checking helpers
    // ==================================================

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "run stopped on error");
        end
    endtask

    function automatic logic [6:0] segments(input logic [3:0] digit);
        return (digit > 4'd9) ? 7'h00 : SEG_TABLE[digit];
    endfunction

    // word k of the frame sits in bits 8k+7 to 8k.
    function automatic logic [63:0] reference_frame(input time_pkg::clock_time_t t);
        logic [63:0] frame;
        logic [3:0]  digits [4];
        digits[0] = t.hr[7:4];
        digits[1] = t.hr[3:0];
        digits[2] = t.min[7:4];
        digits[3] = t.min[3:0];
        frame = '0;
        for (int d = 0; d < time_pkg::DIGITS; d++) begin
            frame[16*d +: 8] = {time_pkg::DIGIT_TAG, 2'(d)};
            frame[16*d + 8 +: 8] = {1'b0, segments(digits[d])};
        end
        return frame;
    endfunction

    task automatic queue_frame(input time_pkg::clock_time_t t);
        logic [63:0] frame;
        frame = reference_frame(t);
        for (int k = 0; k < 8; k++) begin
            exp_words.push_back(frame[8*k +: 8]);
        end
    endtask

    function automatic link_pkg::i2c_item_t make_item(input link_pkg::i2c_kind_e kind,
                                                      input logic rw,
                                                      input logic [1:0] count,
                                                      input logic [7:0] data);
        link_pkg::i2c_item_t it;
        it = '0;
        it.valid = 1'b1;
        it.kind = kind;
        it.rw = rw;
        it.count = count;
        it.data = data;
        if (kind == link_pkg::START) begin
            it.addr = RTC_ADDR;
        end
        return it;
    endfunction

    task automatic expect_write(input time_pkg::clock_time_t t);
        exp_items.push_back(make_item(link_pkg::START, 1'b0, 2'd0, 8'h00));
        exp_items.push_back(make_item(link_pkg::DATA, 1'b0, 2'd0, link_pkg::RTC_TIME_REG));
        exp_items.push_back(make_item(link_pkg::DATA, 1'b0, 2'd0, t.sec));
        exp_items.push_back(make_item(link_pkg::DATA, 1'b0, 2'd0, t.min));
        exp_items.push_back(make_item(link_pkg::DATA, 1'b0, 2'd0, t.hr));
    endtask

    task automatic expect_read(input time_pkg::clock_time_t t);
        exp_items.push_back(make_item(link_pkg::START, 1'b0, 2'd0, 8'h00));
        exp_items.push_back(make_item(link_pkg::DATA, 1'b0, 2'd0, link_pkg::RTC_TIME_REG));
        exp_items.push_back(make_item(link_pkg::START, 1'b1, 2'd3, 8'h00));
        exp_reads.push_back(t);
    endtask

    task automatic send_packet(input logic [7:0] header, input logic [7:0] hr_bcd,
                               input logic [7:0] min_bcd, input logic [7:0] sec_bcd);
        logic [7:0] bytes [4];
        bytes = '{header, hr_bcd, min_bcd, sec_bcd};
        if (header == link_pkg::HEADER_SET) begin
            exp_answers.push_back(link_pkg::ANSWER_ACK);
            exp_time.hr = hr_bcd;
            exp_time.min = min_bcd;
            exp_time.sec = sec_bcd;
            expect_write(exp_time);
        end else begin
            exp_answers.push_back(link_pkg::ANSWER_NACK);
        end
        for (int b = 0; b < link_pkg::PACKET_BYTES; b++) begin
            repeat ($urandom_range(0, 2)) @(negedge clk);
            rx.valid = 1'b1;
            rx.data = bytes[b];
            @(negedge clk);
            rx = '0;
        end
    endtask

    // ==================================================
    // RTC and display models
    // ==================================================

    task automatic send_read_bytes();
        // the master needs a cycle before the first byte.
        @(negedge clk);
        for (int i = 0; i < 3; i++) begin
            repeat ($urandom_range(0, 3)) @(negedge clk);
            i2c_rd.valid = 1'b1;
            case (i)
                0: i2c_rd.data = rtc_time.sec;
                1: i2c_rd.data = rtc_time.min;
                default: i2c_rd.data = rtc_time.hr;
            endcase
            @(negedge clk);
            i2c_rd = '0;
        end
    endtask

    initial begin : rtc_model
        link_pkg::i2c_item_t item;
        int                  data_idx;
        i2c_ready = 1'b0;
        i2c_rd = '0;
        rtc_time = '0;
        data_idx = 0;
        wait (!reset);
        @(negedge clk);
        i2c_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (i2c_cmd.valid) begin
                item = i2c_cmd;
                @(negedge clk);
                i2c_ready = 1'b0;
                if (item.kind == link_pkg::START) begin
                    data_idx = 0;
                    if (item.rw) begin
                        send_read_bytes();
                    end
                end else begin
                    // byte 0 is the register pointer.
                    case (data_idx)
                        1: rtc_time.sec = item.data;
                        2: rtc_time.min = item.data;
                        3: rtc_time.hr = item.data;
                        default: ;
                    endcase
                    data_idx++;
                end
                repeat ($urandom_range(1, 4)) @(negedge clk);
                i2c_ready = 1'b1;
            end
        end
    end

    initial begin : display_model
        display_ready = 1'b0;
        forever begin
            @(negedge clk);
            display_ready = ($urandom_range(0, 3) != 0);
        end
    end

    // ==================================================
    // comparing process
    // ==================================================

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            report_failure("timeout, the expected traffic did not finish");
        end else if (!reset) begin
            if (answer.valid) begin
                if (exp_answers.size() == 0) begin
                    report_failure("answer strobe without a packet");
                end else begin
                    check_value("answer.data", 32'(answer.data), 32'(exp_answers.pop_front()));
                end
            end

            if (i2c_cmd.valid && !i2c_ready) begin
                report_failure("i2c item issued while i2c_ready was low");
            end else if (i2c_cmd.valid) begin
                if (exp_items.size() == 0) begin
                    report_failure("i2c item that no transaction called for");
                end else begin
                    check_value("i2c_cmd", 32'(i2c_cmd), 32'(exp_items.pop_front()));
                end
            end

            if (display.valid && !display_ready) begin
                report_failure("display word sent while display_ready was low");
            end else if (display.valid) begin
                if (exp_words.size() == 0) begin
                    report_failure("display word outside of any frame");
                end else begin
                    exp_word = exp_words.pop_front();
                    got_word = display.word;
                    // the hour-units dp blinks.
                    if (word_idx == 3) begin
                        exp_word[7] = 1'b0;
                        got_word[7] = 1'b0;
                    end
                    check_value("display.word", 32'(got_word), 32'(exp_word));
                    if (word_idx == 7) begin
                        word_idx = 0;
                        frames_done++;
                    end else begin
                        word_idx++;
                    end
                end
            end

            check_value("buzz", 32'(buzz), 32'(cycle >= buzz_from && cycle < buzz_until));

            if (i2c_rd.valid) begin
                rd_bytes++;
                if (rd_bytes == 3) begin
                    rd_bytes = 0;
                    if (exp_reads.size() == 0) begin
                        report_failure("read bytes without a read transaction");
                    end else begin
                        read_time = exp_reads.pop_front();
                        queue_frame(read_time);
                        if (read_time.hr != last_hr) begin
                            last_hr = read_time.hr;
                            buzz_from = cycle + 2;
                            buzz_until = cycle + 2 + CHIME_CYCLES;
                        end
                    end
                end
            end
        end
    end

    // ==================================================
    // stimulus
    // ==================================================

    initial begin
        void'($urandom(SEED));
        reset = 1'b1;
        rx = '0;
        exp_time = '0;
        last_hr = '0;
        expect_read(exp_time);
        repeat (3) @(negedge clk);
        reset = 1'b0;

        wait (frames_done == 1);
        @(negedge clk);
        send_packet(link_pkg::HEADER_SET, 8'h09, 8'h59, 8'h30);
        expect_read(exp_time);

        wait (frames_done == 2);
        @(negedge clk);
        send_packet(8'h55, 8'h10, 8'h20, 8'h30);
        expect_read(exp_time);

        wait (frames_done == 3);
        @(negedge clk);
        check_value("rtc stored time", 32'(rtc_time), 32'(exp_time));
        send_packet(link_pkg::HEADER_SET, 8'h23, 8'h45, 8'h07);
        expect_read(exp_time);

        wait (frames_done == 4);
        @(negedge clk);
        expect_read(exp_time);

        wait (frames_done == 5);
        repeat (20) @(negedge clk);
        if (exp_answers.size() != 0 || exp_items.size() != 0 || exp_words.size() != 0 ||
            exp_reads.size() != 0) begin
            $display("expected traffic was still outstanding at the end");
            $display("TEST RESULT: FAIL");
            $fatal(1, "run stopped on error");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule
